// File: src/uart_pkg.sv
// uart package: 8N1 frame constants, register map and bus/status structs
package uart_pkg;

	// fixed 8N1 framing
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = DATA_BITS + 2;

	// register byte addresses
	localparam logic [3:0] ADDR_DATA = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;

	// wishbone classic, master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// receive fifo payload
	typedef struct packed {
		logic                 frame_error;
		logic [DATA_BITS-1:0] data;
	} rx_word_t;

	// status register, bit 0 is tx_empty
	typedef struct packed {
		logic rx_frame_error;
		logic tx_busy;
		logic overrun;
		logic frame_error;
		logic rx_full;
		logic rx_empty;
		logic tx_full;
		logic tx_empty;
	} uart_status_t;

endpackage

// File: src/uart_fifo.sv
// uart fifo: synchronous first-word-fall-through buffer for any payload type
`timescale 1ns/1ns

module uart_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// storage, no reset needed
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves on a lone push or pop
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// head word always visible
	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

	// the drivers must respect the flags
	a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// File: src/uart_baud_gen.sv
// uart baud generator: restartable bit-period counter with half or full first tick
`timescale 1ns/1ns

module uart_baud_gen #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic half,
	output logic tick
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= FULL_LOAD;
		end else if (start) begin
			// half load puts the first tick at mid-bit
			cnt <= half ? HALF_LOAD : FULL_LOAD;
		end else if (cnt == '0) begin
			cnt <= FULL_LOAD;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// free running, the cores ignore ticks while idle
	assign tick = (cnt == '0);

endmodule

// File: src/uart_tx_core.sv
// uart transmit core: pops the tx fifo and shifts out 8N1 frames LSB first
`timescale 1ns/1ns

module uart_tx_core
	import uart_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 fifo_empty,
	input  logic [DATA_BITS-1:0] fifo_data,
	output logic                 fifo_pop,
	output logic                 tx,
	output logic                 tx_busy
);

	localparam int BIT_W = $clog2(FRAME_BITS);
	// index of the stop bit once the start bit is gone
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(FRAME_BITS - 2);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_shift
	} state_t;

	state_t state;
	logic [BIT_W-1:0] bit_cnt;
	// data bits plus stop bit
	logic [FRAME_BITS-2:0] shift_reg;
	logic tick;
	logic frame_done;

	uart_baud_gen #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_baud (
		.clk  (clk),
		.reset(reset),
		.start(fifo_pop),
		.half (1'b0),
		.tick (tick)
	);

	assign frame_done = (state == st_shift) && tick && (bit_cnt == LAST_BIT);

	// pop from idle, or right at the end of a stop bit for back-to-back frames
	assign fifo_pop = !fifo_empty && ((state == st_idle) || frame_done);
	assign tx_busy = (state != st_idle) || fifo_pop;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			tx <= 1'b1;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (fifo_pop) begin
						state <= st_start;
						tx <= 1'b0;
					end
				end
				st_start: begin
					if (tick) begin
						state <= st_shift;
						tx <= shift_reg[0];
						bit_cnt <= '0;
					end
				end
				st_shift: begin
					if (frame_done) begin
						state <= fifo_pop ? st_start : st_idle;
						tx <= !fifo_pop;
					end else if (tick) begin
						tx <= shift_reg[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			shift_reg <= {1'b1, fifo_data};
		end else if (tick && state != st_idle) begin
			shift_reg <= shift_reg >> 1;
		end
	end

	// line idles high between frames
	a_idle_high: assert property (@(posedge clk) disable iff (reset) (state == st_idle) |-> tx);

endmodule

// File: src/uart_rx_core.sv
// uart receive core: finds start bits, samples mid-bit and pushes bytes with their frame flag
`timescale 1ns/1ns

module uart_rx_core
	import uart_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     rx,
	input  logic     fifo_full,
	output logic     fifo_push,
	output rx_word_t fifo_word,
	output logic     frame_error,
	output logic     overrun
);

	localparam int BIT_W = $clog2(DATA_BITS);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_check,
		st_data,
		st_stop
	} state_t;

	state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic tick;
	logic stop_sample;
	logic [BIT_W-1:0] bit_cnt;
	logic [DATA_BITS-1:0] shift_reg;

	// two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = (state == st_idle) && rx_prev && !rx_sync;

	// first tick lands in the middle of the start bit
	uart_baud_gen #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_baud (
		.clk  (clk),
		.reset(reset),
		.start(start_edge),
		.half (1'b1),
		.tick (tick)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start_edge) begin
						state <= st_check;
					end
				end
				st_check: begin
					if (tick) begin
						// high again at mid start bit means a glitch
						state <= rx_sync ? st_idle : st_data;
						bit_cnt <= '0;
					end
				end
				st_data: begin
					if (tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT) begin
							state <= st_stop;
						end
					end
				end
				st_stop: begin
					if (tick) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == st_data && tick) begin
			shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
		end
	end

	assign stop_sample = (state == st_stop) && tick;
	assign fifo_word = '{frame_error: !rx_sync, data: shift_reg};
	assign fifo_push = stop_sample && !fifo_full;
	assign overrun = stop_sample && fifo_full;
	assign frame_error = stop_sample && !rx_sync;

	// a lost word meets a full fifo a whole bit after the last data sample
	a_overrun: assert property (@(posedge clk) disable iff (reset)
		overrun |-> fifo_full && $past(state == st_stop, CLKS_PER_BIT - 1));

endmodule

// File: src/uart_wb_regs.sv
// uart register block: wishbone classic slave with DATA and STATUS registers
`timescale 1ns/1ns

module uart_wb_regs
	import uart_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  wb_req_t              wb_req,
	output wb_rsp_t              wb_rsp,
	output logic                 tx_push,
	output logic [DATA_BITS-1:0] tx_data,
	input  logic                 tx_empty,
	input  logic                 tx_full,
	input  logic                 rx_empty,
	input  logic                 rx_full,
	output logic                 rx_pop,
	input  rx_word_t             rx_head,
	input  logic                 tx_busy,
	input  logic                 frame_error,
	input  logic                 overrun
);

	logic ack;
	logic access;
	logic sel_data;
	logic sel_status;
	logic fe_sticky;
	logic ovr_sticky;
	logic clr_fe;
	logic clr_ovr;
	logic [31:0] rd_data;
	logic [31:0] rd_mux;
	uart_status_t status;

	// act once per request, in the cycle before ack
	assign access = wb_req.cyc && wb_req.stb && !ack;
	assign sel_data = (wb_req.adr == ADDR_DATA);
	assign sel_status = (wb_req.adr == ADDR_STATUS);

	// full fifo drops the write, empty fifo reads zero
	assign tx_push = access && wb_req.we && sel_data && !tx_full;
	assign tx_data = wb_req.dat[DATA_BITS-1:0];
	assign rx_pop = access && !wb_req.we && sel_data && !rx_empty;

	// write one to clear bits 4 and 5
	assign clr_fe = access && wb_req.we && sel_status && wb_req.dat[4];
	assign clr_ovr = access && wb_req.we && sel_status && wb_req.dat[5];

	assign status = '{
		rx_frame_error: !rx_empty && rx_head.frame_error,
		tx_busy:        tx_busy,
		overrun:        ovr_sticky,
		frame_error:    fe_sticky,
		rx_full:        rx_full,
		rx_empty:       rx_empty,
		tx_full:        tx_full,
		tx_empty:       tx_empty
	};

	always_comb begin
		rd_mux = '0;
		if (sel_data && !rx_empty) begin
			// byte in 7:0, its frame error in bit 8
			rd_mux = 32'(rx_head);
		end else if (sel_status) begin
			rd_mux = 32'(status);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			fe_sticky <= 1'b0;
			ovr_sticky <= 1'b0;
		end else begin
			ack <= access;
			// a new event wins over a clear in the same cycle
			fe_sticky <= (fe_sticky && !clr_fe) || frame_error;
			ovr_sticky <= (ovr_sticky && !clr_ovr) || overrun;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_data <= rd_mux;
		end
	end

	assign wb_rsp = '{ack: ack, dat: rd_data};

	// ack answers a request still held by the master, one pulse only
	a_ack_single: assert property (@(posedge clk) disable iff (reset)
		ack |-> wb_req.cyc && wb_req.stb && !$past(ack));

endmodule

// File: src/uart_top.sv
// uart top: wishbone register block, tx and rx fifos and both serial cores
`timescale 1ns/1ns

module uart_top
	import uart_pkg::*;
#(
	parameter int CLKS_PER_BIT = 868,
	parameter int TX_DEPTH = 16,
	parameter int RX_DEPTH = 16
) (
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	input  logic    rx,
	output logic    tx
);

	logic tx_push;
	logic tx_pop;
	logic tx_empty;
	logic tx_full;
	logic tx_busy;
	logic [DATA_BITS-1:0] tx_wdata;
	logic [DATA_BITS-1:0] tx_head;
	logic rx_push;
	logic rx_pop;
	logic rx_empty;
	logic rx_full;
	logic frame_error;
	logic overrun;
	rx_word_t rx_word;
	rx_word_t rx_head;

	uart_wb_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.tx_push    (tx_push),
		.tx_data    (tx_wdata),
		.tx_empty   (tx_empty),
		.tx_full    (tx_full),
		.rx_empty   (rx_empty),
		.rx_full    (rx_full),
		.rx_pop     (rx_pop),
		.rx_head    (rx_head),
		.tx_busy    (tx_busy),
		.frame_error(frame_error),
		.overrun    (overrun)
	);

	// transmit path
	uart_fifo #(
		.DEPTH    (TX_DEPTH),
		.payload_t(logic [DATA_BITS-1:0])
	) u_tx_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (tx_push),
		.push_data(tx_wdata),
		.pop      (tx_pop),
		.pop_data (tx_head),
		.empty    (tx_empty),
		.full     (tx_full)
	);

	uart_tx_core #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_tx_core (
		.clk       (clk),
		.reset     (reset),
		.fifo_empty(tx_empty),
		.fifo_data (tx_head),
		.fifo_pop  (tx_pop),
		.tx        (tx),
		.tx_busy   (tx_busy)
	);

	// receive path
	uart_rx_core #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_rx_core (
		.clk        (clk),
		.reset      (reset),
		.rx         (rx),
		.fifo_full  (rx_full),
		.fifo_push  (rx_push),
		.fifo_word  (rx_word),
		.frame_error(frame_error),
		.overrun    (overrun)
	);

	uart_fifo #(
		.DEPTH    (RX_DEPTH),
		.payload_t(rx_word_t)
	) u_rx_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (rx_push),
		.push_data(rx_word),
		.pop      (rx_pop),
		.pop_data (rx_head),
		.empty    (rx_empty),
		.full     (rx_full)
	);

endmodule

// File: testbench/uart_checker.sv
// uart checker: decodes the serial lines, predicts bus read data and counts mismatches
`timescale 1ns/1ns

module uart_checker
	import uart_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16,
	parameter int TX_DEPTH = 4,
	parameter int RX_DEPTH = 4
) (
	input logic    clk,
	input logic    reset,
	input wb_req_t wb_req,
	input wb_rsp_t wb_rsp,
	input logic    tx,
	input logic    rx
);

	localparam int HALF = CLKS_PER_BIT / 2;
	localparam int FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;

	int error_count;
	int timeout_count;
	int drop_count;
	int lost_count;
	int frame_count;
	int read_count;

	// bytes accepted by the tx fifo and not yet started on the line
	logic [DATA_BITS-1:0] tx_expect[$];
	// words the rx fifo should hold
	rx_word_t rx_expect[$];

	logic tx_active;
	logic tx_prev;
	logic tx_grid_ok;
	int tx_idx;
	int tx_bit;
	logic [FRAME_BITS-1:0] tx_frame;
	logic [FRAME_BITS-1:0] tx_exp_frame;

	logic rx_active;
	logic rx_prev;
	int rx_idx;
	int rx_bit;
	logic [DATA_BITS-1:0] rx_bits;
	rx_word_t rx_got;

	initial begin
		error_count = 0;
		timeout_count = 0;
		drop_count = 0;
		lost_count = 0;
		frame_count = 0;
		read_count = 0;
	end

	// reference: line image of one 8N1 frame, start bit at index 0
	function automatic logic [FRAME_BITS-1:0] frame_of(input logic [DATA_BITS-1:0] b);
		return {1'b1, b, 1'b0};
	endfunction

	// reference: DATA read value, byte in 7:0 and its frame error in bit 8
	function automatic logic [31:0] read_value_of(input rx_word_t w);
		return {23'b0, w.frame_error, w.data};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic note_problem(input string what);
		$display("error: %s", what);
		error_count++;
	endtask

	task automatic note_timeout(input string what);
		$display("timeout: %s", what);
		timeout_count++;
	endtask

	task automatic final_check();
		if (tx_expect.size() != 0) begin
			note_problem("bytes were written but never sent on tx");
		end
		if (rx_expect.size() != 0) begin
			note_problem("received bytes were never read back");
		end
	endtask

	task automatic report();
		$display("checker: %0d mismatches, %0d timeouts, %0d tx frames, %0d data reads",
			error_count, timeout_count, frame_count, read_count);
	endtask

	// tx side, sampled mid-cycle
	always @(negedge clk) begin
		if (reset) begin
			tx_active = 1'b0;
			tx_prev = 1'b1;
		end else begin
			// a write is judged against occupancy before a pop on the same edge
			if (wb_rsp.ack && wb_req.cyc && wb_req.stb && wb_req.we
					&& wb_req.adr == ADDR_DATA) begin
				if (tx_expect.size() < TX_DEPTH) begin
					tx_expect.push_back(wb_req.dat[DATA_BITS-1:0]);
				end else begin
					drop_count++;
				end
			end
			if (!tx_active && tx_prev && !tx) begin
				// start bit, the fifo head left on this edge
				tx_active = 1'b1;
				tx_idx = 0;
				tx_grid_ok = 1'b1;
				tx_frame = '0;
				if (tx_expect.size() == 0) begin
					note_problem("a frame started on tx with no byte waiting");
					tx_exp_frame = '1;
				end else begin
					tx_exp_frame = frame_of(tx_expect.pop_front());
				end
			end
			if (tx_active) begin
				tx_bit = tx_idx / CLKS_PER_BIT;
				if (tx_idx % CLKS_PER_BIT == HALF) begin
					tx_frame[tx_bit] = tx;
				end
				// every cycle of a bit must hold that bit
				if (tx_grid_ok && tx !== tx_exp_frame[tx_bit]) begin
					$display("FAILED tx at cycle %0d of frame: got %h, expected %h",
						tx_idx, tx, tx_exp_frame[tx_bit]);
					error_count++;
					tx_grid_ok = 1'b0;
				end
				if (tx_idx == FRAME_CLKS - 1) begin
					check_value("tx frame", 32'(tx_frame), 32'(tx_exp_frame));
					frame_count++;
					tx_active = 1'b0;
				end else begin
					tx_idx++;
				end
			end
			tx_prev = tx;
		end
	end

	// rx side: bus reads, then the line decoder
	always @(negedge clk) begin
		if (reset) begin
			rx_active = 1'b0;
			rx_prev = 1'b1;
		end else begin
			if (wb_rsp.ack && wb_req.cyc && wb_req.stb && !wb_req.we
					&& wb_req.adr == ADDR_DATA) begin
				if (rx_expect.size() == 0) begin
					check_value("wb_rsp.dat DATA", wb_rsp.dat, 32'h0);
				end else begin
					check_value("wb_rsp.dat DATA", wb_rsp.dat,
						read_value_of(rx_expect.pop_front()));
				end
				read_count++;
			end
			if (!rx_active && rx_prev && !rx) begin
				rx_active = 1'b1;
				rx_idx = 0;
			end else if (rx_active) begin
				rx_idx++;
				if (rx_idx == HALF && rx) begin
					// line back high at mid start bit
					rx_active = 1'b0;
				end else if (rx_idx > HALF && (rx_idx - HALF) % CLKS_PER_BIT == 0) begin
					rx_bit = (rx_idx - HALF) / CLKS_PER_BIT;
					if (rx_bit <= DATA_BITS) begin
						rx_bits[rx_bit-1] = rx;
					end else begin
						// stop bit middle
						if (rx_expect.size() >= RX_DEPTH) begin
							lost_count++;
						end else begin
							rx_got = '{frame_error: !rx, data: rx_bits};
							rx_expect.push_back(rx_got);
						end
						rx_active = 1'b0;
					end
				end
			end
			rx_prev = rx;
		end
	end

endmodule

// File: testbench/uart_tb.sv
// uart testbench: bus master sequences over loopback and forced serial frames
`timescale 1ns/1ns

module uart_tb
	import uart_pkg::*;
();

	localparam int CLKS_PER_BIT = 16;
	localparam int TX_DEPTH = 4;
	localparam int RX_DEPTH = 4;
	localparam logic [31:0] SEED = 32'h4d85_5894;
	localparam int ACK_LIMIT = 50;
	localparam int POLL_LIMIT = 1000;

	// STATUS bits, low to high
	localparam logic [31:0] M_TX_EMPTY = 32'h01;
	localparam logic [31:0] M_TX_FULL = 32'h02;
	localparam logic [31:0] M_RX_EMPTY = 32'h04;
	localparam logic [31:0] M_RX_FULL = 32'h08;
	localparam logic [31:0] M_FE = 32'h10;
	localparam logic [31:0] M_OVR = 32'h20;
	localparam logic [31:0] M_TX_BUSY = 32'h40;
	localparam logic [31:0] M_RX_FE = 32'h80;

	logic clk;
	logic reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic rx;
	logic tx;
	logic loopback;
	logic forced_rx;

	assign rx = loopback ? tx : forced_rx;

	initial clk = 1'b0;
	always #50 clk = ~clk;

	uart_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.TX_DEPTH    (TX_DEPTH),
		.RX_DEPTH    (RX_DEPTH)
	) u_dut (
		.clk   (clk),
		.reset (reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.rx    (rx),
		.tx    (tx)
	);

	uart_checker #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.TX_DEPTH    (TX_DEPTH),
		.RX_DEPTH    (RX_DEPTH)
	) u_chk (
		.clk   (clk),
		.reset (reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.tx    (tx),
		.rx    (rx)
	);

	// one classic cycle, held until ack, then stb drops for a cycle
	task automatic bus_access(input logic we, input logic [3:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_rsp.ack && waited < ACK_LIMIT);
		if (!wb_rsp.ack) begin
			u_chk.note_timeout("no ack on a bus access");
		end
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic bus_write(input logic [3:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [3:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'h0, rdat);
	endtask

	task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
			input string what);
		int polls;
		logic [31:0] d;
		polls = 0;
		do begin
			bus_read(ADDR_STATUS, d);
			polls++;
		end while ((d & mask) != want && polls < POLL_LIMIT);
		if ((d & mask) != want) begin
			u_chk.note_timeout({"STATUS never showed ", what});
		end
	endtask

	// raw 8N1 frame on the forced line with a chosen stop bit
	task automatic send_raw_frame(input logic [7:0] b, input logic stop);
		logic [FRAME_BITS-1:0] bits;
		bits = {stop, b, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++) begin
			@(posedge clk);
			forced_rx <= bits[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
		@(posedge clk);
		forced_rx <= 1'b1;
	endtask

	initial begin
		logic [31:0] d;
		logic [7:0] b;
		logic dropped;
		int drops_before;
		int lost_before;
		wb_req = '0;
		reset = 1'b1;
		loopback = 1'b0;
		forced_rx = 1'b1;
		d = $urandom(SEED);
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		loopback <= 1'b1;
		@(negedge clk);

		// reset state and unmapped address
		u_chk.check_value("tx", 32'(tx), 32'h1);
		bus_read(ADDR_STATUS, d);
		u_chk.check_value("wb_rsp.dat STATUS", d, M_TX_EMPTY | M_RX_EMPTY);
		bus_write(4'hC, 32'hFFFF_FFFF);
		bus_read(4'hC, d);
		u_chk.check_value("wb_rsp.dat unmapped", d, 32'h0);

		// single loopback byte
		b = 8'($urandom);
		bus_write(ADDR_DATA, 32'(b));
		// popped at once, so the fifo is empty and the transmitter busy
		bus_read(ADDR_STATUS, d);
		u_chk.check_value("wb_rsp.dat STATUS", d, M_TX_EMPTY | M_RX_EMPTY | M_TX_BUSY);
		wait_status(M_RX_EMPTY, 32'h0, "a received byte");
		bus_read(ADDR_DATA, d);
		u_chk.check_value("wb_rsp.dat loopback", d, 32'(b));

		// burst with one write into a full tx fifo
		drops_before = u_chk.drop_count;
		dropped = 1'b0;
		for (int i = 0; i < 8; i++) begin
			bus_read(ADDR_STATUS, d);
			if ((d & M_TX_FULL) != 0 && !dropped) begin
				bus_write(ADDR_DATA, 32'($urandom) & 32'hFF);
				dropped = 1'b1;
			end
			wait_status(M_TX_FULL, 32'h0, "tx fifo space");
			bus_write(ADDR_DATA, 32'($urandom) & 32'hFF);
		end
		u_chk.check_value("dropped writes", 32'(u_chk.drop_count - drops_before), 32'h1);
		for (int i = 0; i < 8; i++) begin
			wait_status(M_RX_EMPTY, 32'h0, "a burst byte");
			bus_read(ADDR_DATA, d);
		end
		wait_status(M_TX_BUSY, 32'h0, "an idle transmitter");

		// forced frame with a low stop bit
		@(posedge clk);
		loopback <= 1'b0;
		b = 8'($urandom);
		send_raw_frame(b, 1'b0);
		wait_status(M_RX_EMPTY, 32'h0, "the bad frame");
		bus_read(ADDR_STATUS, d);
		u_chk.check_value("wb_rsp.dat STATUS", d, M_TX_EMPTY | M_FE | M_RX_FE);
		bus_read(ADDR_DATA, d);
		u_chk.check_value("wb_rsp.dat bad frame", d, {23'b0, 1'b1, b});
		// empty fifo reads zero
		bus_read(ADDR_DATA, d);
		bus_write(ADDR_STATUS, M_FE);
		bus_read(ADDR_STATUS, d);
		u_chk.check_value("wb_rsp.dat STATUS", d, M_TX_EMPTY | M_RX_EMPTY);

		// five frames into a 4-deep rx fifo
		@(posedge clk);
		loopback <= 1'b1;
		lost_before = u_chk.lost_count;
		for (int i = 0; i < 5; i++) begin
			wait_status(M_TX_FULL, 32'h0, "tx fifo space");
			bus_write(ADDR_DATA, 32'($urandom) & 32'hFF);
		end
		wait_status(M_OVR | M_TX_BUSY, M_OVR, "overrun with an idle transmitter");
		bus_read(ADDR_STATUS, d);
		u_chk.check_value("wb_rsp.dat STATUS", d, M_TX_EMPTY | M_RX_FULL | M_OVR);
		for (int i = 0; i < 4; i++) begin
			bus_read(ADDR_DATA, d);
		end
		bus_read(ADDR_DATA, d);
		u_chk.check_value("wb_rsp.dat after overrun", d, 32'h0);
		u_chk.check_value("lost words", 32'(u_chk.lost_count - lost_before), 32'h1);
		bus_write(ADDR_STATUS, M_OVR);
		bus_read(ADDR_STATUS, d);
		u_chk.check_value("wb_rsp.dat STATUS", d, M_TX_EMPTY | M_RX_EMPTY);

		u_chk.final_check();
		u_chk.report();
		if (u_chk.error_count == 0 && u_chk.timeout_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_baud_gen.sv
src/uart_tx_core.sv
src/uart_rx_core.sv
src/uart_wb_regs.sv
src/uart_top.sv
testbench/uart_checker.sv
testbench/uart_tb.sv

// File: Bender.yml
package:
  name: uart_wb

sources:
  - src/uart_pkg.sv
  - src/uart_fifo.sv
  - src/uart_baud_gen.sv
  - src/uart_tx_core.sv
  - src/uart_rx_core.sv
  - src/uart_wb_regs.sv
  - src/uart_top.sv
  - target: test
    files:
      - testbench/uart_checker.sv
      - testbench/uart_tb.sv
